//--- Bender.yml
package:
  name: trs_io

sources:
  - trs_bus_pkg.sv
  - host_cmd_pkg.sv
  - edge_sync.sv
  - spi_target.sv
  - host_cmd_decoder.sv
  - esp_request.sv
  - trs_bus_port.sv
  - shared_ram.sv
  - trs_io_top.sv
  - target: test
    files:
      - tb_trs_io_top.sv

//--- edge_sync.sv
module edge_sync (
  input  logic clk,
  input  logic arst_n,
  input  logic d,
  output logic q,
  output logic rise,
  output logic fall
);

  logic meta;
  logic sync;
  logic hist;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      meta <= 1'b0;
      sync <= 1'b0;
      hist <= 1'b0;
      rise <= 1'b0;
      fall <= 1'b0;
    end else begin
      meta <= d;
      sync <= meta;
      hist <= sync;
      rise <= sync & ~hist;
      fall <= ~sync & hist;
    end
  end

  // Level lines up with the edge pulses
  assign q = hist;

endmodule

//--- esp_request.sv
module esp_request (
  input  logic                      clk,
  input  logic                      arst_n,
  input  trs_bus_pkg::trs_bus_t     bus,
  input  logic                      esp_done_rise,
  output logic                      esp_sel,
  output logic                      esp_req,
  output logic                      esp_wait,
  output host_cmd_pkg::esp_status_e esp_s
);

  import trs_bus_pkg::*;
  import host_cmd_pkg::*;

  typedef logic [$clog2(ESP_REQ_CYCLES + 1)-1:0] req_cnt_t;

  logic     io_port;
  logic     hd_port;
  logic     sel_rise;
  req_cnt_t count;

  assign io_port = (bus.addr.io.port == TRS_IO_PORT);
  assign hd_port = (bus.addr.io.port[7:4] == FREHD_PORT_HI);
  assign esp_sel = (io_port || hd_port) && !(bus.in_n && bus.out_n);

  // Status follows the access type directly
  always_comb begin
    esp_s = trs_io_in;
    if (io_port && !bus.out_n) begin
      esp_s = trs_io_out;
    end else if (hd_port && !bus.in_n) begin
      esp_s = frehd_in;
    end else if (hd_port && !bus.out_n) begin
      esp_s = frehd_out;
    end
  end

  edge_sync u_sel_sync (.clk, .arst_n, .d(esp_sel), .q(), .rise(sel_rise), .fall());

  // WAIT holds the Z80 until the ESP reports done
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count    <= '0;
      esp_req  <= 1'b0;
      esp_wait <= 1'b0;
    end else if (sel_rise) begin
      count    <= req_cnt_t'(ESP_REQ_CYCLES);
      esp_req  <= 1'b1;
      esp_wait <= 1'b1;
    end else begin
      if (esp_done_rise) begin
        esp_wait <= 1'b0;
      end
      if (count == req_cnt_t'(1)) begin
        esp_req <= 1'b0;
      end
      if (count != '0) begin
        count <= count - req_cnt_t'(1);
      end
    end
  end

endmodule

//--- host_cmd_decoder.sv
module host_cmd_decoder (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic [7:0]              rx_byte,
  input  logic                    rx_valid,
  input  logic                    frame_start,
  input  logic [7:0]              trs_d_in,
  input  logic [7:0]              peek_data,
  output logic                    tx_load,
  output logic [7:0]              tx_byte,
  output host_cmd_pkg::host_cmd_t cmd,
  output logic                    action
);

  import host_cmd_pkg::*;

  typedef enum logic {
    st_idle,
    st_params
  } state_e;

  state_e     state;
  logic [1:0] remain;
  logic [1:0] idx;
  logic [1:0] param_cnt;
  logic       known;
  logic [2:0] peek_dly;

  // Parameter bytes per opcode
  always_comb begin
    known = 1'b1;
    case (rx_byte)
      ram_poke:              param_cnt = 2'd3;
      ram_peek:              param_cnt = 2'd2;
      dbus_write:            param_cnt = 2'd1;
      get_cookie, dbus_read: param_cnt = 2'd0;
      default: begin
        param_cnt = 2'd0;
        known     = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= st_idle;
      remain <= '0;
      idx    <= '0;
      action <= 1'b0;
    end else begin
      action <= 1'b0;
      if (frame_start) begin
        state <= st_idle;
      end else if (rx_valid && state == st_idle && known) begin
        idx    <= '0;
        remain <= param_cnt;
        if (param_cnt == 2'd0) begin
          action <= 1'b1;
        end else begin
          state <= st_params;
        end
      end else if (rx_valid && state == st_params) begin
        idx    <= idx + 2'd1;
        remain <= remain - 2'd1;
        if (remain == 2'd1) begin
          action <= 1'b1;
          state  <= st_idle;
        end
      end
    end
  end

  // Opcode and parameter capture, unknown opcodes leave cmd alone
  always_ff @(posedge clk) begin
    if (rx_valid && !frame_start) begin
      if (state == st_idle && known) begin
        cmd.op <= host_cmd_e'(rx_byte);
      end else if (state == st_params) begin
        case (idx)
          2'd0:    cmd.p0 <= rx_byte;
          2'd1:    cmd.p1 <= rx_byte;
          default: cmd.p2 <= rx_byte;
        endcase
      end
    end
  end

  // Peek data leaves port B two cycles after action
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      peek_dly <= '0;
      tx_load  <= 1'b0;
    end else begin
      peek_dly <= {peek_dly[1:0], action && (cmd.op == ram_peek)};
      tx_load  <= peek_dly[2] || (action && (cmd.op inside {get_cookie, dbus_read}));
    end
  end

  always_ff @(posedge clk) begin
    if (peek_dly[2]) begin
      tx_byte <= peek_data;
    end else if (action && cmd.op == dbus_read) begin
      tx_byte <= trs_d_in;
    end else if (action && cmd.op == get_cookie) begin
      tx_byte <= COOKIE;
    end
  end

endmodule

//--- host_cmd_pkg.sv
package host_cmd_pkg;

  typedef enum logic [7:0] {
    get_cookie = 8'd0,
    ram_poke   = 8'd1,
    ram_peek   = 8'd2,
    dbus_read  = 8'd3,
    dbus_write = 8'd4
  } host_cmd_e;

  // Answer to get_cookie, lets the ESP detect the card
  localparam logic [7:0] COOKIE = 8'hAF;

  typedef struct packed {
    host_cmd_e  op;
    logic [7:0] p0;
    logic [7:0] p1;
    logic [7:0] p2;
  } host_cmd_t;

  // Tells the ESP which access raised the request
  typedef enum logic [2:0] {
    trs_io_in  = 3'd0,
    trs_io_out = 3'd1,
    frehd_in   = 3'd2,
    frehd_out  = 3'd3
  } esp_status_e;

endpackage

//--- shared_ram.sv
module shared_ram (
  input  logic                               clk,
  input  logic                               a_en,
  input  logic                               a_regce,
  input  logic                               a_we,
  input  logic [trs_bus_pkg::RAM_ADDR_W-1:0] a_addr,
  input  logic [7:0]                         a_wdata,
  output logic [7:0]                         a_rdata,
  input  logic                               b_en,
  input  logic                               b_regce,
  input  logic                               b_we,
  input  logic [trs_bus_pkg::RAM_ADDR_W-1:0] b_addr,
  input  logic [7:0]                         b_wdata,
  output logic [7:0]                         b_rdata
);

  import trs_bus_pkg::*;

  logic [7:0] mem [2**RAM_ADDR_W];
  logic [7:0] a_q;
  logic [7:0] b_q;

  // Port A, write-first
  always @(posedge clk) begin
    if (a_en) begin
      if (a_we) begin
        mem[a_addr] <= a_wdata;
        a_q         <= a_wdata;
      end else begin
        a_q <= mem[a_addr];
      end
    end
    if (a_regce) begin
      a_rdata <= a_q;
    end
  end

  // Port B, read-first
  always @(posedge clk) begin
    if (b_en) begin
      b_q <= mem[b_addr];
      if (b_we) begin
        mem[b_addr] <= b_wdata;
      end
    end
    if (b_regce) begin
      b_rdata <= b_q;
    end
  end

endmodule

//--- spi_target.sv
module spi_target (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       sck_rise,
  input  logic       sck_fall,
  input  logic       cs_n_s,
  input  logic       cs_fall,
  input  logic       mosi_s,
  input  logic       tx_load,
  input  logic [7:0] tx_byte,
  output logic [7:0] rx_byte,
  output logic       rx_valid,
  output logic       frame_start,
  output logic       miso
);

  logic [2:0] bit_cnt;
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;
  logic       pending;
  logic       last_bit;

  assign last_bit = sck_rise && !cs_n_s && (bit_cnt == 3'd7);

  // Mode 0, sample on the rising SCK edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt     <= '0;
      rx_valid    <= 1'b0;
      frame_start <= 1'b0;
    end else begin
      frame_start <= cs_fall;
      rx_valid    <= last_bit && !pending;
      if (cs_n_s) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sck_rise && !cs_n_s) begin
      rx_shift <= {rx_shift[6:0], mosi_s};
    end
  end

  assign rx_byte = rx_shift;

  // A loaded response owns the next whole byte frame
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pending <= 1'b0;
    end else if (tx_load) begin
      pending <= 1'b1;
    end else if (last_bit) begin
      pending <= 1'b0;
    end
  end

  // No shift before the first rising edge, or the MSB would be lost
  always_ff @(posedge clk) begin
    if (tx_load) begin
      tx_shift <= tx_byte;
    end else if (pending && sck_fall && (bit_cnt != 3'd0)) begin
      tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  assign miso = pending & tx_shift[7];

endmodule

//--- tb_trs_io_top.sv
module tb_trs_io_top;

  import trs_bus_pkg::*;
  import host_cmd_pkg::*;

  localparam int MAX_VECS    = 64;
  localparam int SYNC_CYCLES = 3;
  localparam int HALF_SCK    = 4;
  localparam int FRAME_GAP   = 10;
  localparam int HOLD_CYCLES = 16;

  // Operation kinds in the upper byte of the first vector column
  localparam logic [7:0]  OP_SPI    = 8'h00;
  localparam logic [7:0]  OP_MEM_RD = 8'h01;
  localparam logic [7:0]  OP_MEM_WR = 8'h02;
  localparam logic [7:0]  OP_IO_IN  = 8'h03;
  localparam logic [7:0]  OP_IO_OUT = 8'h04;
  localparam logic [15:0] END_OP    = 16'hffff;

  logic        clk;
  logic        arst_n;
  trs_bus_t    bus;
  logic [7:0]  trs_d_in;
  logic        sck;
  logic        mosi;
  logic        cs_n;
  logic        esp_done;
  logic [7:0]  trs_d_out;
  logic        trs_d_oe;
  logic        trs_oe_n;
  logic        trs_dir;
  logic        esp_req;
  logic        esp_wait;
  esp_status_e esp_s;
  logic        miso;

  // Kind and opcode, address, data and expected byte per operation
  logic [15:0] vec [4*MAX_VECS];
  int          n_vecs;
  logic [31:0] lfsr;
  logic [7:0]  frame_q [$];

  trs_io_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
    if (got !== exp) begin
      stop_with_failure($sformatf("ERR %s exp %h got %h", name, exp, got));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      stop_with_failure($sformatf("ERR %s exp %h got %h", name, exp, got));
    end
  endtask

  task automatic check_status(input esp_status_e exp, input esp_status_e got);
    if (got !== exp) begin
      stop_with_failure($sformatf("ERR esp_s exp %h got %h", exp, got));
    end
  endtask

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic random_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_next(lfsr);
      b    = {b[6:0], lfsr[0]};
    end
  endtask

  // Status the ESP should see for an access to this port
  function automatic esp_status_e io_status(input logic [7:0] port, input logic out);
    if (port[7:4] == FREHD_PORT_HI) begin
      return out ? frehd_out : frehd_in;
    end
    return out ? trs_io_out : trs_io_in;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // MISO sampled just before each rising SCK edge
  task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];
      wait_cycles(HALF_SCK);
      rx  = {rx[6:0], miso};
      sck = 1'b1;
      wait_cycles(HALF_SCK);
      sck = 1'b0;
    end
  endtask

  task automatic send_frame(output logic [7:0] last_rx);
    cs_n = 1'b0;
    for (int i = 0; i < frame_q.size(); i++) begin
      shift_byte(frame_q[i], last_rx);
    end
    wait_cycles(HALF_SCK);
    cs_n = 1'b1;
    wait_cycles(FRAME_GAP);
  endtask

  task automatic spi_command(input logic [7:0] op, input logic [15:0] addr,
                             input logic [7:0] data, input logic [7:0] exp);
    logic [7:0] rx;
    logic [7:0] filler;
    frame_q.delete();
    frame_q.push_back(op);
    case (op)
      ram_poke: begin
        frame_q.push_back(addr[7:0]);
        frame_q.push_back(addr[15:8]);
        frame_q.push_back(data);
      end
      ram_peek: begin
        frame_q.push_back(addr[7:0]);
        frame_q.push_back(addr[15:8]);
      end
      dbus_write: frame_q.push_back(data);
      dbus_read:  trs_d_in = data;
      default: ;
    endcase
    send_frame(rx);
    // MISO idles low while no answer is pending
    check_byte("miso", 8'h00, rx);
    // Answer comes back in a separate dummy frame
    if (op inside {get_cookie, ram_peek, dbus_read}) begin
      random_byte(filler);
      frame_q.delete();
      frame_q.push_back(filler);
      send_frame(rx);
      check_byte("miso", exp, rx);
    end
  endtask

  task automatic release_bus();
    bus.rd_n  = 1'b1;
    bus.wr_n  = 1'b1;
    bus.in_n  = 1'b1;
    bus.out_n = 1'b1;
    wait_cycles(1);
    bus.addr.mem = '0;
    wait_cycles(SYNC_CYCLES + 2);
    check_flag("trs_oe_n", 1'b1, trs_oe_n);
  endtask

  task automatic mem_access(input logic write, input logic [15:0] addr,
                            input logic [7:0] data, input logic [7:0] exp);
    bus.addr.mem = addr;
    if (write) begin
      trs_d_in = data;
      bus.wr_n = 1'b0;
    end else begin
      bus.rd_n = 1'b0;
    end
    wait_cycles(1);
    check_flag("trs_oe_n", 1'b0, trs_oe_n);
    check_flag("trs_dir", write, trs_dir);
    wait_cycles(HOLD_CYCLES - 1);
    check_flag("trs_d_oe", !write, trs_d_oe);
    if (!write) begin
      check_byte("trs_d_out", exp, trs_d_out);
    end
    release_bus();
  endtask

  task automatic io_access(input logic out, input logic [15:0] addr,
                           input logic [7:0] data, input logic [7:0] exp);
    int cycles;
    bus.addr.mem = addr;
    if (out) begin
      trs_d_in  = data;
      bus.out_n = 1'b0;
    end else begin
      bus.in_n = 1'b0;
    end
    wait_cycles(1);
    check_status(io_status(addr[7:0], out), esp_s);
    check_flag("trs_oe_n", 1'b0, trs_oe_n);
    check_flag("trs_dir", out, trs_dir);
    cycles = 1;
    while (!esp_req) begin
      if (cycles > 4 * SYNC_CYCLES) begin
        stop_with_failure("esp_req never rose after the port was selected");
      end
      wait_cycles(1);
      cycles++;
    end
    check_flag("esp_wait", 1'b1, esp_wait);
    // Request pulse length is fixed
    cycles = 0;
    while (esp_req) begin
      if (cycles > ESP_REQ_CYCLES) begin
        stop_with_failure("esp_req stayed high past the request length");
      end
      wait_cycles(1);
      cycles++;
    end
    if (cycles != ESP_REQ_CYCLES) begin
      stop_with_failure($sformatf("esp_req was high for %0d cycles, not %0d",
                                  cycles, ESP_REQ_CYCLES));
    end
    check_flag("esp_wait", 1'b1, esp_wait);
    esp_done = 1'b1;
    cycles   = 0;
    while (esp_wait) begin
      if (cycles > 4 * SYNC_CYCLES) begin
        stop_with_failure("esp_wait did not drop after esp_done rose");
      end
      wait_cycles(1);
      cycles++;
    end
    // Synchronizer delay plus the clearing flop
    if (cycles != SYNC_CYCLES + 1) begin
      stop_with_failure($sformatf("esp_wait dropped %0d cycles after esp_done, not %0d",
                                  cycles, SYNC_CYCLES + 1));
    end
    check_flag("trs_d_oe", !out, trs_d_oe);
    if (!out) begin
      check_byte("trs_d_out", exp, trs_d_out);
    end
    esp_done = 1'b0;
    release_bus();
  endtask

  task automatic apply_vector(input int idx);
    logic [15:0] op;
    logic [15:0] addr;
    logic [7:0]  data;
    logic [7:0]  exp;
    op   = vec[4*idx];
    addr = vec[4*idx+1];
    data = vec[4*idx+2][7:0];
    exp  = vec[4*idx+3][7:0];
    case (op[15:8])
      OP_SPI:    spi_command(op[7:0], addr, data, exp);
      OP_MEM_RD: mem_access(1'b0, addr, data, exp);
      OP_MEM_WR: mem_access(1'b1, addr, data, exp);
      OP_IO_IN:  io_access(1'b0, addr, data, exp);
      OP_IO_OUT: io_access(1'b1, addr, data, exp);
      default: stop_with_failure($sformatf("vector %0d has an unknown operation %h", idx, op));
    endcase
  endtask

  initial begin
    arst_n       = 1'b0;
    bus.addr.mem = '0;
    bus.rd_n     = 1'b1;
    bus.wr_n     = 1'b1;
    bus.in_n     = 1'b1;
    bus.out_n    = 1'b1;
    trs_d_in     = '0;
    sck          = 1'b0;
    mosi         = 1'b0;
    cs_n         = 1'b1;
    esp_done     = 1'b0;
    lfsr         = 32'hccf5_5ea9;
    $readmemh("trs_io_vectors.mem", vec);
    while (n_vecs < MAX_VECS && vec[4*n_vecs] !== END_OP) begin
      n_vecs++;
    end
    if (n_vecs == 0 || n_vecs == MAX_VECS) begin
      stop_with_failure("vector file is empty or lacks its end marker");
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    wait_cycles(4);
    for (int i = 0; i < n_vecs; i++) begin
      apply_vector(i);
    end
    $display(">>> PASS");
    $finish;
  end

  // Watchdog sized from the vector count
  initial begin
    wait (n_vecs > 0);
    repeat (n_vecs * 2000) @(posedge clk);
    $display("Run did not finish within %0d cycles", n_vecs * 2000);
    $display(">>> FAIL");
    $fatal(1);
  end

endmodule

//--- trs_bus_pkg.sv
package trs_bus_pkg;

  // Only the upper 32 KB exists, selected by A15
  localparam int RAM_ADDR_W = 15;

  localparam logic [7:0] TRS_IO_PORT   = 8'd31;
  localparam logic [3:0] FREHD_PORT_HI = 4'hC;

  // Request pulse length in clk cycles
  localparam int ESP_REQ_CYCLES = 50;

  // I/O cycles put the port number on the low address byte
  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] port;
  } trs_io_addr_t;

  typedef union packed {
    logic [15:0]  mem;
    trs_io_addr_t io;
  } trs_addr_u;

  typedef struct packed {
    trs_addr_u addr;
    logic      rd_n;
    logic      wr_n;
    logic      in_n;
    logic      out_n;
  } trs_bus_t;

endpackage

//--- trs_bus_port.sv
module trs_bus_port (
  input  logic                               clk,
  input  logic                               arst_n,
  input  trs_bus_pkg::trs_bus_t              bus,
  input  logic                               rd_fall,
  input  logic                               wr_fall,
  input  logic                               esp_sel,
  input  logic [7:0]                         trs_d_in,
  input  host_cmd_pkg::host_cmd_t            cmd,
  input  logic                               action,
  output logic                               ram_a_en,
  output logic                               ram_a_regce,
  output logic                               ram_a_we,
  output logic [trs_bus_pkg::RAM_ADDR_W-1:0] ram_a_addr,
  output logic [7:0]                         ram_a_wdata,
  input  logic [7:0]                         ram_a_rdata,
  output logic [7:0]                         trs_d_out,
  output logic                               trs_d_oe,
  output logic                               trs_oe_n,
  output logic                               trs_dir
);

  import trs_bus_pkg::*;
  import host_cmd_pkg::*;

  logic       ram_hit;
  logic       start;
  logic [2:0] seq;
  logic       acc_wr;
  logic       capture;

  assign ram_hit = bus.addr.mem[15];

  // The strobe pulse is the check cycle
  assign start = (rd_fall || wr_fall) && ram_hit;

  // en, regce and capture follow one cycle apart
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      seq    <= '0;
      acc_wr <= 1'b0;
    end else begin
      seq <= {seq[1:0], start};
      if (start) begin
        acc_wr <= wr_fall;
      end
    end
  end

  assign ram_a_en    = seq[0];
  assign ram_a_we    = seq[0] && acc_wr;
  assign ram_a_regce = seq[1] && !acc_wr;
  assign capture     = seq[2] && !acc_wr;
  assign ram_a_addr  = bus.addr.mem[RAM_ADDR_W-1:0];
  assign ram_a_wdata = trs_d_in;

  // Data register serves RAM reads and ESP writes to the bus
  always_ff @(posedge clk) begin
    if (capture) begin
      trs_d_out <= ram_a_rdata;
    end else if (action && cmd.op == dbus_write) begin
      trs_d_out <= cmd.p0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      trs_d_oe <= 1'b0;
    end else begin
      trs_d_oe <= !bus.rd_n || !bus.in_n;
    end
  end

  assign trs_oe_n = !((ram_hit && !(bus.rd_n && bus.wr_n)) || esp_sel);
  assign trs_dir  = bus.rd_n && bus.in_n;

endmodule

//--- trs_io_top.f
trs_bus_pkg.sv
host_cmd_pkg.sv
edge_sync.sv
spi_target.sv
host_cmd_decoder.sv
esp_request.sv
trs_bus_port.sv
shared_ram.sv
trs_io_top.sv
tb_trs_io_top.sv

//--- trs_io_top.sv
module trs_io_top (
  input  logic                      clk,
  input  logic                      arst_n,
  input  trs_bus_pkg::trs_bus_t     bus,
  input  logic [7:0]                trs_d_in,
  input  logic                      sck,
  input  logic                      mosi,
  input  logic                      cs_n,
  input  logic                      esp_done,
  output logic [7:0]                trs_d_out,
  output logic                      trs_d_oe,
  output logic                      trs_oe_n,
  output logic                      trs_dir,
  output logic                      esp_req,
  output logic                      esp_wait,
  output host_cmd_pkg::esp_status_e esp_s,
  output logic                      miso
);

  import trs_bus_pkg::*;
  import host_cmd_pkg::*;

  logic                  rd_fall;
  logic                  wr_fall;
  logic                  sck_rise;
  logic                  sck_fall;
  logic                  cs_n_s;
  logic                  cs_fall;
  logic                  esp_done_rise;
  logic                  mosi_meta;
  logic                  mosi_s;
  logic [7:0]            rx_byte;
  logic                  rx_valid;
  logic                  frame_start;
  logic                  tx_load;
  logic [7:0]            tx_byte;
  host_cmd_t             cmd;
  logic                  action;
  logic                  esp_sel;
  logic                  ram_a_en;
  logic                  ram_a_regce;
  logic                  ram_a_we;
  logic [RAM_ADDR_W-1:0] ram_a_addr;
  logic [7:0]            ram_a_wdata;
  logic [7:0]            ram_a_rdata;
  logic                  b_en;
  logic                  b_regce;
  logic                  b_we;
  logic [RAM_ADDR_W-1:0] b_addr;
  logic [7:0]            peek_data;

  edge_sync u_rd_sync (.clk, .arst_n, .d(bus.rd_n), .q(), .rise(), .fall(rd_fall));
  edge_sync u_wr_sync (.clk, .arst_n, .d(bus.wr_n), .q(), .rise(), .fall(wr_fall));
  edge_sync u_sck_sync (.clk, .arst_n, .d(sck), .q(), .rise(sck_rise), .fall(sck_fall));
  edge_sync u_cs_sync (.clk, .arst_n, .d(cs_n), .q(cs_n_s), .rise(), .fall(cs_fall));
  edge_sync u_done_sync (.clk, .arst_n, .d(esp_done), .q(), .rise(esp_done_rise), .fall());

  // MOSI is only sampled on SCK edges, two flops are enough
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mosi_meta <= 1'b0;
      mosi_s    <= 1'b0;
    end else begin
      mosi_meta <= mosi;
      mosi_s    <= mosi_meta;
    end
  end

  spi_target u_spi (.*);
  host_cmd_decoder u_dec (.*);
  esp_request u_esp (.*);
  trs_bus_port u_bus (.*);

  // Host side of the RAM, A15 dropped from {p1, p0}
  assign b_en   = action && (cmd.op == ram_poke || cmd.op == ram_peek);
  assign b_we   = action && (cmd.op == ram_poke);
  assign b_addr = RAM_ADDR_W'({cmd.p1, cmd.p0});

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      b_regce <= 1'b0;
    end else begin
      b_regce <= action && (cmd.op == ram_peek);
    end
  end

  shared_ram u_ram (
    .clk,
    .a_en(ram_a_en),
    .a_regce(ram_a_regce),
    .a_we(ram_a_we),
    .a_addr(ram_a_addr),
    .a_wdata(ram_a_wdata),
    .a_rdata(ram_a_rdata),
    .b_en,
    .b_regce,
    .b_we,
    .b_addr,
    .b_wdata(cmd.p2),
    .b_rdata(peek_data)
  );

endmodule

//--- trs_io_vectors.mem
// Columns: kind/opcode, address, data, expected byte
// Kind in high byte: 00 SPI command (low byte opcode), 01 RAM read, 02 RAM write, 03 IN, 04 OUT
0000 0000 0000 00af
0001 8000 005a 0000
0002 8000 0000 005a
0001 8123 00c3 0000
0001 8124 003c 0000
0002 8123 0000 00c3
0002 8124 0000 003c
0201 8200 0096 0000
0002 8200 0000 0096
0001 8301 00e7 0000
0101 8301 0000 00e7
0001 ffff 0011 0000
0101 ffff 0000 0011
0004 0000 00a5 0000
0301 001f 0000 00a5
0003 0000 004e 004e
0401 00c4 0077 0000
0301 00c2 0000 00a5
0000 0000 0000 00af
ffff 0000 0000 0000
